// File: Makefile
VERILATOR ?= verilator
TOP       := mips_cpu_tb
FILE_LIST := list.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: list.f
mips_isa_pkg.sv
mips_cpu_pkg.sv
mips_decoder.sv
mips_regfile.sv
mips_alu.sv
mips_pc_unit.sv
mips_cpu_harvard.sv
mips_cpu_props.sv
mips_cpu_tb.sv

// File: mips_alu.sv
`timescale 1ns/100ps

module mips_alu (
    input  logic [31:0]           op_a,
    input  logic [31:0]           op_b,
    input  logic [31:0]           instr,
    input  mips_cpu_pkg::alu_op_e alu_op,
    input  logic                  use_imm,
    input  logic                  imm_signed,
    input  logic                  branch_eq,
    input  logic                  branch_ne,
    output logic [31:0]           result,
    output logic [31:0]           hi_result,
    output logic [31:0]           lo_result,
    output logic [31:0]           mem_addr,
    output logic                  branch_taken
);

    logic [15:0] imm;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic [31:0] operand;
    logic [4:0]  shamt;
    logic [63:0] product;
    logic        operands_equal;

    assign imm = instr[mips_isa_pkg::imm_lsb +: 16];
    assign imm_sext = {{16{imm[15]}}, imm};
    assign imm_zext = {16'h0000, imm};
    assign shamt = instr[mips_isa_pkg::shamt_lsb +: 5];

    // second operand is rt or the extended immediate
    assign operand = use_imm ? (imm_signed ? imm_sext : imm_zext) : op_b;

    always_comb begin
        case (alu_op)
            mips_cpu_pkg::alu_add:  result = op_a + operand;
            mips_cpu_pkg::alu_sub:  result = op_a - operand;
            mips_cpu_pkg::alu_and:  result = op_a & operand;
            mips_cpu_pkg::alu_or:   result = op_a | operand;
            mips_cpu_pkg::alu_xor:  result = op_a ^ operand;
            mips_cpu_pkg::alu_nor:  result = ~(op_a | operand);
            mips_cpu_pkg::alu_slt:  result = {31'd0, $signed(op_a) < $signed(operand)};
            mips_cpu_pkg::alu_sltu: result = {31'd0, op_a < operand};
            // shifts act on rt by the shamt field
            mips_cpu_pkg::alu_sll:  result = op_b << shamt;
            mips_cpu_pkg::alu_srl:  result = op_b >> shamt;
            mips_cpu_pkg::alu_sra:  result = 32'($signed(op_b) >>> shamt);
            mips_cpu_pkg::alu_lui:  result = {imm, 16'h0000};
            default:                result = 32'd0;
        endcase
    end

    // unsigned 32x32 product for hi and lo
    assign product = {32'd0, op_a} * {32'd0, op_b};
    assign hi_result = product[63:32];
    assign lo_result = product[31:0];

    // load/store effective address, rs plus signed offset
    assign mem_addr = op_a + imm_sext;

    assign operands_equal = (op_a == op_b);
    assign branch_taken = (branch_eq && operands_equal) || (branch_ne && !operands_equal);

endmodule

// File: mips_cpu_harvard.sv
`timescale 1ns/100ps

module mips_cpu_harvard #(
    parameter logic [31:0] reset_vector = 32'hbfc0_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_enable,
    output logic        active,
    output logic [31:0] register_v0,

    // instruction port, combinational read
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,

    // data port, combinational read and single-cycle write
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);

    mips_cpu_pkg::alu_op_e alu_op;
    mips_cpu_pkg::wb_src_e wb_src;
    logic [4:0]  write_index;
    logic        use_imm;
    logic        imm_signed;
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    logic        hilo_write;
    logic        branch_eq;
    logic        branch_ne;
    logic        jump_imm;
    logic        jump_reg;

    logic        exec;
    logic [31:0] pc;
    logic [31:0] link_addr;
    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic [31:0] alu_result;
    logic [31:0] hi_result;
    logic [31:0] lo_result;
    logic [31:0] mem_addr;
    logic        branch_taken;

    mips_decoder u_decoder (
        .instr       (instr_readdata),
        .alu_op      (alu_op),
        .wb_src      (wb_src),
        .write_index (write_index),
        .use_imm     (use_imm),
        .imm_signed  (imm_signed),
        .reg_write   (reg_write),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .hilo_write  (hilo_write),
        .branch_eq   (branch_eq),
        .branch_ne   (branch_ne),
        .jump_imm    (jump_imm),
        .jump_reg    (jump_reg)
    );

    // all architectural writes happen only on the execute edge
    mips_regfile u_regfile (
        .clk          (clk),
        .reset        (reset),
        .clk_enable   (clk_enable),
        .write_en     (exec && reg_write),
        .hilo_write   (exec && hilo_write),
        .read_index_a (instr_readdata[mips_isa_pkg::rs_lsb +: 5]),
        .read_index_b (instr_readdata[mips_isa_pkg::rt_lsb +: 5]),
        .write_index  (write_index),
        .wb_src       (wb_src),
        .alu_result   (alu_result),
        .mem_data     (data_readdata),
        .link_addr    (link_addr),
        .hi_in        (hi_result),
        .lo_in        (lo_result),
        .read_data_a  (rs_value),
        .read_data_b  (rt_value),
        .register_v0  (register_v0)
    );

    mips_alu u_alu (
        .op_a         (rs_value),
        .op_b         (rt_value),
        .instr        (instr_readdata),
        .alu_op       (alu_op),
        .use_imm      (use_imm),
        .imm_signed   (imm_signed),
        .branch_eq    (branch_eq),
        .branch_ne    (branch_ne),
        .result       (alu_result),
        .hi_result    (hi_result),
        .lo_result    (lo_result),
        .mem_addr     (mem_addr),
        .branch_taken (branch_taken)
    );

    mips_pc_unit #(
        .reset_vector (reset_vector)
    ) u_pc_unit (
        .clk          (clk),
        .reset        (reset),
        .clk_enable   (clk_enable),
        .instr        (instr_readdata),
        .branch_taken (branch_taken),
        .jump_imm     (jump_imm),
        .jump_reg     (jump_reg),
        .rs_value     (rs_value),
        .pc           (pc),
        .link_addr    (link_addr),
        .exec         (exec),
        .active       (active)
    );

    assign instr_address = pc;

    // word accesses only
    assign data_address = {mem_addr[31:2], 2'b00};
    assign data_read = mem_read && exec;
    assign data_write = mem_write && exec;
    assign data_writedata = rt_value;

endmodule

// File: mips_cpu_pkg.sv
package mips_cpu_pkg;

    // alu operation selector
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui,
        alu_multu
    } alu_op_e;

    // register write-back source
    typedef enum logic [2:0] {
        wb_alu,
        wb_mem,
        wb_hi,
        wb_lo,
        wb_link
    } wb_src_e;

    typedef enum logic {
        st_fetch,
        st_exec
    } cpu_state_e;

endpackage

// File: mips_cpu_props.sv
`timescale 1ns/100ps

module mips_cpu_props (
    input logic        clk,
    input logic        reset,
    input logic        clk_enable,
    input logic        active,
    input logic        data_read,
    input logic        data_write,
    input logic [31:0] instr_address,
    input logic [31:0] data_address
);

    // a single instruction is either a load or a store
    no_read_write_overlap: assert property (
        @(posedge clk) disable iff (reset) !(data_read && data_write)
    ) else $error("data_read and data_write high together");

    write_only_while_active: assert property (
        @(posedge clk) disable iff (reset) !active |-> !data_write
    ) else $error("data_write high while the core is halted");

    word_aligned_addresses: assert property (
        @(posedge clk) disable iff (reset)
        instr_address[1:0] == 2'b00 && data_address[1:0] == 2'b00
    ) else $error("instruction or data address not word aligned");

    // once one enabled reset edge has passed, the state is fetch
    no_write_in_reset: assert property (
        @(posedge clk) (reset && $past(reset && clk_enable)) |-> !data_write
    ) else $error("data_write high during reset");

endmodule

// File: mips_cpu_tb.sv
`timescale 1ns/100ps

module mips_cpu_tb;

    localparam logic [31:0] reset_vector = 32'hbfc0_0000;
    localparam int num_tests = 6;
    localparam int words_per_program = 12;
    localparam int reset_cycles = 16;
    // two edges per word, enable gaps stretch that up to 4x, plus reset and slack
    localparam int timeout_cycles =
        num_tests * (words_per_program * 2 * 4 + reset_cycles + 64);

    logic        clk;
    logic        reset;
    logic        clk_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] imem_offset;
    logic [31:0] programs [num_tests][words_per_program];
    int          cycle_count = 0;
    int          tests_done = 0;

    // final v0, plus one data word to inspect after the halt
    logic [31:0] expect_v0 [num_tests] = '{32'h07ff_ed01, 32'h0f0f_fff1, 32'h2152_4111,
                                           32'ha5a5_0041, 32'h0000_001f, 32'h0000_0017};
    logic [31:0] expect_addr [num_tests] = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0020,
                                             32'h0000_007c, 32'h0000_0008, 32'h0000_0010};
    logic [31:0] expect_data [num_tests] = '{32'ha5a5_0000, 32'ha5a5_0004, 32'hdead_beee,
                                             32'ha5a5_0041, 32'ha5a5_0008, 32'hbfc0_0008};

    mips_cpu_harvard #(
        .reset_vector (reset_vector)
    ) u_dut (
        .clk            (clk),
        .reset          (reset),
        .clk_enable     (clk_enable),
        .active         (active),
        .register_v0    (register_v0),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    bind mips_cpu_harvard mips_cpu_props u_props (
        .clk           (clk),
        .reset         (reset),
        .clk_enable    (clk_enable),
        .active        (active),
        .data_read     (data_read),
        .data_write    (data_write),
        .instr_address (instr_address),
        .data_address  (data_address)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // instruction memory sits at the reset vector, nops outside it
    assign imem_offset = instr_address - reset_vector;
    assign instr_readdata = (imem_offset < 32'd1024) ? imem[imem_offset[9:2]] : 32'h0;
    // data memory drives read data only for a strobed read
    assign data_readdata = (data_read && data_address < 32'd1024) ?
                           dmem[data_address[9:2]] : 32'h0;

    always @(posedge clk) begin
        if (reset) begin
            // pattern follows each word's byte address
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= 32'ha5a5_0000 ^ (32'(i) << 2);
            end
        end else if (clk_enable && data_write && data_address < 32'd1024) begin
            dmem[data_address[9:2]] <= data_writedata;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Done: errors found");
            $fatal(1, "timeout, the core did not halt within %0d cycles", timeout_cycles);
        end
    end

    function automatic logic [31:0] r_instr(mips_isa_pkg::funct_e fn, int rs, int rt,
                                            int rd, int sh);
        return {mips_isa_pkg::op_special, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [31:0] i_instr(mips_isa_pkg::opcode_e op, int rs, int rt,
                                            int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // target is the absolute byte address inside the current 256 MB region
    function automatic logic [31:0] j_instr(mips_isa_pkg::opcode_e op, logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    function automatic logic random_enable();
        return $urandom_range(3) != 0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, actual, expected);
            $display("Done: errors found");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic next_cycle(input logic enable);
        @(posedge clk);
        #1;
        clk_enable = enable;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        clk_enable = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
        clk_enable = random_enable();
    endtask

    task automatic load_program(input int t);
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0;
        end
        for (int i = 0; i < words_per_program; i++) begin
            imem[i] = programs[t][i];
        end
    endtask

    // register 2 is v0, 4 is a0, 8 to 15 are t0 to t7, 31 is ra
    task automatic fill_table();
        logic [31:0] halt;
        halt = r_instr(mips_isa_pkg::fn_jr, 0, 0, 0, 0);
        // arithmetic, logic, sra, slt, lui
        programs[0] = '{
            i_instr(mips_isa_pkg::op_addiu, 0, 8, 'h1234),
            i_instr(mips_isa_pkg::op_addiu, 0, 9, -3),
            r_instr(mips_isa_pkg::fn_addu, 8, 9, 10, 0),
            r_instr(mips_isa_pkg::fn_subu, 10, 9, 10, 0),
            i_instr(mips_isa_pkg::op_lui, 0, 11, 'h8000),
            r_instr(mips_isa_pkg::fn_sra, 0, 11, 11, 4),
            i_instr(mips_isa_pkg::op_xori, 11, 11, 'h00ff),
            r_instr(mips_isa_pkg::fn_nor, 11, 10, 11, 0),
            r_instr(mips_isa_pkg::fn_slt, 9, 8, 12, 0),
            r_instr(mips_isa_pkg::fn_addu, 11, 12, 2, 0),
            halt, 32'h0};
        // shifts, zero-extended immediates, sltu, slti
        programs[1] = '{
            i_instr(mips_isa_pkg::op_ori, 0, 8, 'hf0f0),
            r_instr(mips_isa_pkg::fn_sll, 0, 8, 9, 12),
            r_instr(mips_isa_pkg::fn_srl, 0, 9, 10, 8),
            i_instr(mips_isa_pkg::op_andi, 10, 11, 'hff00),
            r_instr(mips_isa_pkg::fn_or, 9, 11, 12, 0),
            r_instr(mips_isa_pkg::fn_sltu, 9, 12, 13, 0),
            i_instr(mips_isa_pkg::op_slti, 9, 14, -1),
            r_instr(mips_isa_pkg::fn_xor, 12, 8, 15, 0),
            r_instr(mips_isa_pkg::fn_addu, 15, 13, 2, 0),
            r_instr(mips_isa_pkg::fn_addu, 2, 14, 2, 0),
            halt, 32'h0};
        // multu then hi and lo
        programs[2] = '{
            i_instr(mips_isa_pkg::op_lui, 0, 8, 'hdead),
            i_instr(mips_isa_pkg::op_ori, 8, 8, 'hbeef),
            i_instr(mips_isa_pkg::op_addiu, 0, 9, -1),
            r_instr(mips_isa_pkg::fn_multu, 8, 9, 0, 0),
            r_instr(mips_isa_pkg::fn_mfhi, 0, 0, 10, 0),
            r_instr(mips_isa_pkg::fn_mflo, 0, 0, 2, 0),
            i_instr(mips_isa_pkg::op_sw, 0, 10, 'h20),
            halt, 32'h0, 32'h0, 32'h0, 32'h0};
        // unaligned effective addresses drop to the word
        programs[3] = '{
            i_instr(mips_isa_pkg::op_addiu, 0, 4, 'h41),
            i_instr(mips_isa_pkg::op_lw, 4, 8, -1),
            i_instr(mips_isa_pkg::op_addiu, 8, 9, 1),
            i_instr(mips_isa_pkg::op_sw, 4, 9, 'h3d),
            i_instr(mips_isa_pkg::op_lw, 4, 2, 'h3b),
            halt, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
        // beq not taken, bne taken, beq taken, delay slots counted in v0
        programs[4] = '{
            i_instr(mips_isa_pkg::op_addiu, 0, 2, 1),
            i_instr(mips_isa_pkg::op_addiu, 0, 8, 5),
            i_instr(mips_isa_pkg::op_beq, 8, 0, 2),
            i_instr(mips_isa_pkg::op_addiu, 2, 2, 2),
            i_instr(mips_isa_pkg::op_bne, 8, 0, 2),
            i_instr(mips_isa_pkg::op_addiu, 2, 2, 4),
            i_instr(mips_isa_pkg::op_addiu, 2, 2, 'h100),
            i_instr(mips_isa_pkg::op_beq, 8, 8, 2),
            i_instr(mips_isa_pkg::op_addiu, 2, 2, 8),
            i_instr(mips_isa_pkg::op_addiu, 2, 2, 'h200),
            halt, i_instr(mips_isa_pkg::op_addiu, 2, 2, 'h10)};
        // jal forward, jalr back through ra, j over the skipped words
        programs[5] = '{
            j_instr(mips_isa_pkg::op_jal, reset_vector + 32'd16),
            i_instr(mips_isa_pkg::op_ori, 0, 2, 1),
            j_instr(mips_isa_pkg::op_j, reset_vector + 32'd32),
            i_instr(mips_isa_pkg::op_addiu, 2, 2, 2),
            r_instr(mips_isa_pkg::fn_jalr, 31, 0, 8, 0),
            i_instr(mips_isa_pkg::op_addiu, 2, 2, 4),
            i_instr(mips_isa_pkg::op_addiu, 2, 2, 'h100),
            i_instr(mips_isa_pkg::op_addiu, 2, 2, 'h200),
            i_instr(mips_isa_pkg::op_sw, 0, 31, 'h10),
            r_instr(mips_isa_pkg::fn_subu, 8, 31, 9, 0),
            halt, r_instr(mips_isa_pkg::fn_addu, 2, 9, 2, 0)};
    endtask

    initial begin
        void'($urandom(32'h44d0_590e));
        reset = 1'b1;
        clk_enable = 1'b0;
        fill_table();
        for (int t = 0; t < num_tests; t++) begin
            load_program(t);
            apply_reset();
            check_value($sformatf("test %0d active after reset", t), {31'd0, active}, 32'd1);
            while (active) begin
                next_cycle(random_enable());
            end
            // halted core must stay frozen
            repeat (4) next_cycle(1'b1);
            check_value($sformatf("test %0d active after halt", t), {31'd0, active}, 32'd0);
            check_value($sformatf("test %0d register_v0", t), register_v0, expect_v0[t]);
            check_value($sformatf("test %0d data word at %h", t, expect_addr[t]),
                        dmem[expect_addr[t][9:2]], expect_data[t]);
            tests_done++;
        end
        if (tests_done == num_tests) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "only %0d of %0d programs completed", tests_done, num_tests);
        end
    end

endmodule

// File: mips_decoder.sv
`timescale 1ns/100ps

module mips_decoder (
    input  logic [31:0]           instr,
    output mips_cpu_pkg::alu_op_e alu_op,
    output mips_cpu_pkg::wb_src_e wb_src,
    output logic [4:0]            write_index,
    output logic                  use_imm,
    output logic                  imm_signed,
    output logic                  reg_write,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  hilo_write,
    output logic                  branch_eq,
    output logic                  branch_ne,
    output logic                  jump_imm,
    output logic                  jump_reg
);

    mips_isa_pkg::opcode_e opcode;
    mips_isa_pkg::funct_e  funct;
    logic [4:0]            rt;
    logic [4:0]            rd;

    assign opcode = mips_isa_pkg::opcode_e'(instr[mips_isa_pkg::opcode_lsb +: 6]);
    assign funct = mips_isa_pkg::funct_e'(instr[mips_isa_pkg::funct_lsb +: 6]);
    assign rt = instr[mips_isa_pkg::rt_lsb +: mips_isa_pkg::reg_index_width];
    assign rd = instr[mips_isa_pkg::rd_lsb +: mips_isa_pkg::reg_index_width];

    always_comb begin
        // defaults describe a no-op
        alu_op = mips_cpu_pkg::alu_add;
        wb_src = mips_cpu_pkg::wb_alu;
        write_index = rd;
        use_imm = 1'b0;
        imm_signed = 1'b0;
        reg_write = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        hilo_write = 1'b0;
        branch_eq = 1'b0;
        branch_ne = 1'b0;
        jump_imm = 1'b0;
        jump_reg = 1'b0;

        case (opcode)
            mips_isa_pkg::op_special: begin
                reg_write = 1'b1;
                case (funct)
                    mips_isa_pkg::fn_addu:  alu_op = mips_cpu_pkg::alu_add;
                    mips_isa_pkg::fn_subu:  alu_op = mips_cpu_pkg::alu_sub;
                    mips_isa_pkg::fn_and:   alu_op = mips_cpu_pkg::alu_and;
                    mips_isa_pkg::fn_or:    alu_op = mips_cpu_pkg::alu_or;
                    mips_isa_pkg::fn_xor:   alu_op = mips_cpu_pkg::alu_xor;
                    mips_isa_pkg::fn_nor:   alu_op = mips_cpu_pkg::alu_nor;
                    mips_isa_pkg::fn_slt:   alu_op = mips_cpu_pkg::alu_slt;
                    mips_isa_pkg::fn_sltu:  alu_op = mips_cpu_pkg::alu_sltu;
                    mips_isa_pkg::fn_sll:   alu_op = mips_cpu_pkg::alu_sll;
                    mips_isa_pkg::fn_srl:   alu_op = mips_cpu_pkg::alu_srl;
                    mips_isa_pkg::fn_sra:   alu_op = mips_cpu_pkg::alu_sra;
                    mips_isa_pkg::fn_mfhi:  wb_src = mips_cpu_pkg::wb_hi;
                    mips_isa_pkg::fn_mflo:  wb_src = mips_cpu_pkg::wb_lo;
                    mips_isa_pkg::fn_jalr: begin
                        jump_reg = 1'b1;
                        wb_src = mips_cpu_pkg::wb_link;
                    end
                    mips_isa_pkg::fn_jr: begin
                        jump_reg = 1'b1;
                        reg_write = 1'b0;
                    end
                    mips_isa_pkg::fn_multu: begin
                        alu_op = mips_cpu_pkg::alu_multu;
                        hilo_write = 1'b1;
                        reg_write = 1'b0;
                    end
                    default: reg_write = 1'b0;
                endcase
            end
            mips_isa_pkg::op_addiu, mips_isa_pkg::op_slti, mips_isa_pkg::op_andi,
            mips_isa_pkg::op_ori, mips_isa_pkg::op_xori, mips_isa_pkg::op_lui: begin
                reg_write = 1'b1;
                use_imm = 1'b1;
                write_index = rt;
                // andi, ori, xori take a zero-extended immediate
                imm_signed = (opcode == mips_isa_pkg::op_addiu) ||
                             (opcode == mips_isa_pkg::op_slti);
                case (opcode)
                    mips_isa_pkg::op_slti: alu_op = mips_cpu_pkg::alu_slt;
                    mips_isa_pkg::op_andi: alu_op = mips_cpu_pkg::alu_and;
                    mips_isa_pkg::op_ori:  alu_op = mips_cpu_pkg::alu_or;
                    mips_isa_pkg::op_xori: alu_op = mips_cpu_pkg::alu_xor;
                    mips_isa_pkg::op_lui:  alu_op = mips_cpu_pkg::alu_lui;
                    default:               alu_op = mips_cpu_pkg::alu_add;
                endcase
            end
            mips_isa_pkg::op_lw: begin
                reg_write = 1'b1;
                mem_read = 1'b1;
                write_index = rt;
                wb_src = mips_cpu_pkg::wb_mem;
            end
            mips_isa_pkg::op_sw:  mem_write = 1'b1;
            mips_isa_pkg::op_beq: branch_eq = 1'b1;
            mips_isa_pkg::op_bne: branch_ne = 1'b1;
            mips_isa_pkg::op_j:   jump_imm = 1'b1;
            mips_isa_pkg::op_jal: begin
                jump_imm = 1'b1;
                reg_write = 1'b1;
                write_index = 5'd31;
                wb_src = mips_cpu_pkg::wb_link;
            end
            default: ;
        endcase
    end

endmodule

// File: mips_isa_pkg.sv
package mips_isa_pkg;

    // instruction word field positions
    localparam int opcode_lsb = 26;
    localparam int rs_lsb = 21;
    localparam int rt_lsb = 16;
    localparam int rd_lsb = 11;
    localparam int shamt_lsb = 6;
    localparam int funct_lsb = 0;
    localparam int imm_lsb = 0;
    localparam int target_lsb = 0;

    localparam int reg_index_width = 5;
    localparam int target_width = 26;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // funct field, special opcode only
    typedef enum logic [5:0] {
        fn_sll   = 6'h00,
        fn_srl   = 6'h02,
        fn_sra   = 6'h03,
        fn_jr    = 6'h08,
        fn_jalr  = 6'h09,
        fn_mfhi  = 6'h10,
        fn_mflo  = 6'h12,
        fn_multu = 6'h19,
        fn_addu  = 6'h21,
        fn_subu  = 6'h23,
        fn_and   = 6'h24,
        fn_or    = 6'h25,
        fn_xor   = 6'h26,
        fn_nor   = 6'h27,
        fn_slt   = 6'h2a,
        fn_sltu  = 6'h2b
    } funct_e;

endpackage

// File: mips_pc_unit.sv
`timescale 1ns/100ps

module mips_pc_unit #(
    parameter logic [31:0] reset_vector = 32'hbfc0_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_enable,
    input  logic [31:0] instr,
    input  logic        branch_taken,
    input  logic        jump_imm,
    input  logic        jump_reg,
    input  logic [31:0] rs_value,
    output logic [31:0] pc,
    output logic [31:0] link_addr,
    output logic        exec,
    output logic        active
);

    mips_cpu_pkg::cpu_state_e state;
    logic [31:0] delay_slot;
    logic [31:0] branch_offset;
    logic [31:0] next_target;

    // return address skips the delay slot
    assign link_addr = delay_slot + 32'd4;
    assign exec = active && (state == mips_cpu_pkg::st_exec);

    assign branch_offset = {{14{instr[mips_isa_pkg::imm_lsb + 15]}},
                            instr[mips_isa_pkg::imm_lsb +: 16], 2'b00};

    // address that follows the delay slot
    always_comb begin
        if (branch_taken) begin
            next_target = delay_slot + branch_offset;
        end else if (jump_imm) begin
            next_target = {delay_slot[31:28],
                           instr[mips_isa_pkg::target_lsb +: mips_isa_pkg::target_width],
                           2'b00};
        end else if (jump_reg) begin
            next_target = rs_value;
        end else begin
            // pc + 8 in straight-line code
            next_target = link_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable) begin
            if (reset) begin
                state <= mips_cpu_pkg::st_fetch;
                pc <= reset_vector;
                delay_slot <= reset_vector + 32'd4;
                active <= 1'b1;
            end else if (active) begin
                if (state == mips_cpu_pkg::st_fetch) begin
                    state <= mips_cpu_pkg::st_exec;
                end else begin
                    state <= mips_cpu_pkg::st_fetch;
                    pc <= delay_slot;
                    delay_slot <= next_target;
                    // delay slot of the jump to 0 just executed, stop here
                    if (delay_slot == 32'd0) begin
                        active <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// File: mips_regfile.sv
`timescale 1ns/100ps

module mips_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_enable,
    input  logic                  write_en,
    input  logic                  hilo_write,
    input  logic [4:0]            read_index_a,
    input  logic [4:0]            read_index_b,
    input  logic [4:0]            write_index,
    input  mips_cpu_pkg::wb_src_e wb_src,
    input  logic [31:0]           alu_result,
    input  logic [31:0]           mem_data,
    input  logic [31:0]           link_addr,
    input  logic [31:0]           hi_in,
    input  logic [31:0]           lo_in,
    output logic [31:0]           read_data_a,
    output logic [31:0]           read_data_b,
    output logic [31:0]           register_v0
);

    logic [31:0] regs [0:31];
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] write_data;

    // write-back select
    always_comb begin
        case (wb_src)
            mips_cpu_pkg::wb_mem:  write_data = mem_data;
            mips_cpu_pkg::wb_hi:   write_data = hi;
            mips_cpu_pkg::wb_lo:   write_data = lo;
            mips_cpu_pkg::wb_link: write_data = link_addr;
            default:               write_data = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (clk_enable) begin
            if (reset) begin
                for (int i = 0; i < 32; i++) begin
                    regs[i] <= 32'd0;
                end
                hi <= 32'd0;
                lo <= 32'd0;
            end else begin
                // $zero is never written
                if (write_en && write_index != 5'd0) begin
                    regs[write_index] <= write_data;
                end
                if (hilo_write) begin
                    hi <= hi_in;
                    lo <= lo_in;
                end
            end
        end
    end

    assign read_data_a = (read_index_a == 5'd0) ? 32'd0 : regs[read_index_a];
    assign read_data_b = (read_index_b == 5'd0) ? 32'd0 : regs[read_index_b];
    assign register_v0 = regs[2];

endmodule
